// File: filelist.f
common/vec_pkg.sv
src/stream_fifo.sv
control/vec_decoder.sv
control/vec_sequencer.sv
lane/vec_regfile.sv
lane/vec_mac_pe.sv
src/mem_port.sv
src/vec_datapath.sv
verif/vec_datapath_sva.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_vec_datapath.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_vec_datapath
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_vec_datapath)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1

// File: verif/tb_vec_datapath.sv
`timescale 1ns/1ns

module tb_vec_datapath;
    localparam int WAIT_LIMIT = 2000;
    localparam int W          = vec_pkg::LANE_W;

    logic            clk, rst_n;
    logic            i_instr_valid, o_busy, o_done;
    vec_pkg::instr_t i_instr;
    logic            o_mem_rd, o_mem_wr, i_mem_rvalid;
    vec_pkg::maddr_t o_mem_addr;
    vec_pkg::vword_t o_mem_wdata, i_mem_rdata;
    logic            i_stream_valid, o_stream_ready, o_stream_valid, i_stream_ready;
    vec_pkg::vword_t i_stream_data, o_stream_data;

    integer          seed = 32'h9d1a;
    vec_pkg::vword_t mem [vec_pkg::maddr_t];   // memory model, also the reference memory
    vec_pkg::vword_t ref_rf [vec_pkg::VRF_DEPTH];
    vec_pkg::vword_t stream_q [$];
    int              tests = 0;
    int              failed = 0;
    bit              timed_out = 1'b0;

    tb_clkgen clkgen_i (.o_clk(clk), .o_rst_n(rst_n));

    vec_datapath #(.FIFO_DEPTH(8)) dut_i (
        .clk(clk), .i_rst_n(rst_n), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_busy(o_busy), .o_done(o_done), .o_mem_rd(o_mem_rd), .o_mem_wr(o_mem_wr),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rvalid(i_mem_rvalid),
        .i_mem_rdata(i_mem_rdata), .i_stream_valid(i_stream_valid),
        .i_stream_data(i_stream_data), .o_stream_ready(o_stream_ready),
        .o_stream_valid(o_stream_valid), .o_stream_data(o_stream_data),
        .i_stream_ready(i_stream_ready)
    );

    tb_checker chk_i (
        .clk(clk), .i_rst_n(rst_n), .i_mem_wr(o_mem_wr), .i_mem_addr(o_mem_addr),
        .i_mem_wdata(o_mem_wdata), .i_stream_valid(o_stream_valid),
        .i_stream_data(o_stream_data), .i_stream_ready(i_stream_ready)
    );

    function automatic int rnd(input int m);
        rnd = ($random(seed) & 32'h7fffffff) % m;
    endfunction

    function automatic vec_pkg::vword_t rnd_word();
        rnd_word = {$random(seed), $random(seed)};
    endfunction

    // memory answers one read after 1 to 4 cycles
    initial begin
        int              delay;
        logic            pending;
        vec_pkg::maddr_t addr;
        pending      = 1'b0;
        delay        = 0;
        addr         = '0;
        i_mem_rvalid = 1'b0;
        i_mem_rdata  = '0;
        forever begin
            @(posedge clk);
            if (o_mem_rd && rst_n) begin
                pending = 1'b1;
                addr    = o_mem_addr;
                delay   = 1 + rnd(4);
            end
            #5;
            i_mem_rvalid = 1'b0;
            if (pending) begin
                delay--;
                if (delay == 0) begin
                    pending      = 1'b0;
                    i_mem_rvalid = 1'b1;
                    i_mem_rdata  = mem.exists(addr) ? mem[addr] : {4{addr}};
                end
            end
        end
    end

    // stream in from the queue, random ready on stream out
    initial begin
        logic xfer;
        i_stream_valid = 1'b0;
        i_stream_data  = '0;
        i_stream_ready = 1'b0;
        forever begin
            @(posedge clk);
            xfer = i_stream_valid && o_stream_ready && rst_n;
            #5;
            if (xfer) void'(stream_q.pop_front());
            i_stream_valid = (stream_q.size() != 0);
            i_stream_data  = (stream_q.size() != 0) ? stream_q[0] : '0;
            i_stream_ready = (rnd(2) != 0);
        end
    end

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic run_instr(input string name, input vec_pkg::vop_e op, input int vd,
                             input int vs, input int len_m1, input int base);
        int n;
        int mark;
        if (timed_out) return;
        mark          = chk_i.errors;
        i_instr       = {op, 4'(vd), 4'(vs), 4'(len_m1), 2'b00, 16'(base)};
        i_instr_valid = 1'b1;
        @(posedge clk);
        #5 i_instr_valid = 1'b0;
        chk_i.check_flag("o_busy after issue", o_busy, 1'b1);
        n = 0;
        while (!o_done && !timed_out) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout({"o_done of ", name});
            end else begin
                @(posedge clk);
                #5;
            end
        end
        if (timed_out) return;
        @(posedge clk);
        #5;
        chk_i.check_flag("o_busy after o_done", o_busy, 1'b0);
        n = 0;
        while (chk_i.pending() != 0 && !timed_out) begin     // output FIFO may still drain
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout({"expected words of ", name});
            end else begin
                @(posedge clk);
                #5;
            end
        end
        if (timed_out) return;
        tests++;
        if (chk_i.errors != mark) failed++;
        $display("test %0d %s: %s", tests, name, (chk_i.errors != mark) ? "failed" : "ok");
    endtask

    task automatic do_load(input int vd, input int n, input int base);
        vec_pkg::maddr_t a;
        for (int k = 0; k < n; k++) begin
            a = vec_pkg::maddr_t'(base + k);
            if (!mem.exists(a)) mem[a] = rnd_word();
            ref_rf[(vd + k) % 16] = mem[a];
        end
        run_instr("VLOAD", vec_pkg::VLOAD, vd, 0, n - 1, base);
    endtask

    task automatic do_store(input int vs, input int n, input int base);
        vec_pkg::maddr_t a;
        for (int k = 0; k < n; k++) begin
            a      = vec_pkg::maddr_t'(base + k);
            mem[a] = ref_rf[(vs + k) % 16];
            chk_i.expect_write(a, ref_rf[(vs + k) % 16]);
        end
        run_instr("VSTORE", vec_pkg::VSTORE, 0, vs, n - 1, base);
    endtask

    task automatic do_streamout(input int vs, input int n);
        for (int k = 0; k < n; k++) chk_i.expect_out(ref_rf[(vs + k) % 16]);
        run_instr("VSTREAMOUT", vec_pkg::VSTREAMOUT, 0, vs, n - 1, 0);
    endtask

    task automatic do_macc(input int vs, input int vd, input int n);
        vec_pkg::vword_t w, s, d;
        for (int k = 0; k < n; k++) begin
            w = rnd_word();
            s = ref_rf[(vs + k) % 16];
            d = ref_rf[(vd + k) % 16];
            stream_q.push_back(w);
            for (int l = 0; l < vec_pkg::LANES; l++) begin
                d[l*W +: W] = W'(w[l*W +: W] * s[l*W +: W] + d[l*W +: W]);
            end
            ref_rf[(vd + k) % 16] = d;
        end
        run_instr("VMACC", vec_pkg::VMACC, vd, vs, n - 1, 0);
    endtask

    initial begin
        int n;
        int vs;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        n = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("reset release");
            end else begin
                @(posedge clk);
            end
        end
        if (!timed_out) begin
            @(posedge clk);
            #5;
            chk_i.check_flag("o_busy", o_busy, 1'b0);
            chk_i.check_flag("o_done", o_done, 1'b0);
            chk_i.check_flag("o_mem_rd", o_mem_rd, 1'b0);
            chk_i.check_flag("o_mem_wr", o_mem_wr, 1'b0);
            chk_i.check_flag("o_stream_valid", o_stream_valid, 1'b0);
            chk_i.check_flag("o_stream_ready", o_stream_ready, 1'b1);
            tests++;
            if (chk_i.errors != 0) failed++;
            $display("test %0d reset: %s", tests, (chk_i.errors != 0) ? "failed" : "ok");

            do_load(0, 16, rnd(65536));    // seeds every register
            do_streamout(0, 16);
            for (int t = 0; t < 30 && !timed_out; t++) begin
                case (rnd(4))
                    0: do_load(rnd(16), 1 + rnd(16), rnd(65536));
                    1: do_store(rnd(16), 1 + rnd(16), rnd(65536));
                    2: begin
                        n  = 1 + rnd(8);
                        vs = rnd(16);
                        do_macc(vs, (vs + n + rnd(17 - 2 * n)) % 16, n);
                    end
                    default: do_streamout(rnd(16), 1 + rnd(16));
                endcase
            end
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed, chk_i.checks, chk_i.errors);
        if (failed == 0 && chk_i.errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verif/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input logic            clk,
    input logic            i_rst_n,
    input logic            i_mem_wr,
    input vec_pkg::maddr_t i_mem_addr,
    input vec_pkg::vword_t i_mem_wdata,
    input logic            i_stream_valid,
    input vec_pkg::vword_t i_stream_data,
    input logic            i_stream_ready
);
    vec_pkg::maddr_t exp_addr_q [$];
    vec_pkg::vword_t exp_wdata_q [$];
    vec_pkg::vword_t exp_out_q [$];
    int              errors = 0;
    int              checks = 0;

    task automatic expect_write(input vec_pkg::maddr_t addr, input vec_pkg::vword_t data);
        exp_addr_q.push_back(addr);
        exp_wdata_q.push_back(data);
    endtask

    task automatic expect_out(input vec_pkg::vword_t data);
        exp_out_q.push_back(data);
    endtask

    function automatic int pending();
        pending = exp_addr_q.size() + exp_out_q.size();
    endfunction

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // memory writes, in issue order
    always @(posedge clk) begin
        if (i_rst_n && i_mem_wr) begin
            checks++;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("Unexpected memory write to address %h at %0t", i_mem_addr, $time);
            end else begin
                if (i_mem_addr !== exp_addr_q[0] || i_mem_wdata !== exp_wdata_q[0]) begin
                    errors++;
                    $display("FAIL %0t: write %h <= %h, expected %h <= %h", $time,
                             i_mem_addr, i_mem_wdata, exp_addr_q[0], exp_wdata_q[0]);
                end
                void'(exp_addr_q.pop_front());
                void'(exp_wdata_q.pop_front());
            end
        end
    end

    // output stream transfers
    always @(posedge clk) begin
        if (i_rst_n && i_stream_valid && i_stream_ready) begin
            checks++;
            if (exp_out_q.size() == 0) begin
                errors++;
                $display("Unexpected output stream word %h at %0t", i_stream_data, $time);
            end else begin
                if (i_stream_data !== exp_out_q[0]) begin
                    errors++;
                    $display("FAIL %0t: stream out %h, expected %h", $time,
                             i_stream_data, exp_out_q[0]);
                end
                void'(exp_out_q.pop_front());
            end
        end
    end

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;     // 40 ns period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        #5 o_rst_n = 1'b1;
    end

endmodule

// File: verif/vec_datapath_sva.sv
`timescale 1ns/1ns

module vec_datapath_sva (
    input logic            clk,
    input logic            i_rst_n,
    input logic            o_busy,
    input logic            o_done,
    input logic            o_mem_rd,
    input logic            o_mem_wr,
    input logic            o_stream_valid,
    input logic            i_stream_ready,
    input vec_pkg::vword_t o_stream_data
);
    done_while_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_done |-> o_busy) else $error("o_done pulsed while o_busy low");

    idle_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_done |=> (!o_busy && !o_done)) else $error("o_busy or o_done high after o_done");

    // memory strobes belong to a running instruction
    mem_while_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_mem_rd || o_mem_wr) |-> o_busy) else $error("memory strobe while o_busy low");

    // a stalled output word stays put
    out_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_stream_valid && !i_stream_ready) |=> (o_stream_valid && $stable(o_stream_data)))
        else $error("output stream word dropped or changed under back-pressure");

endmodule

bind vec_datapath vec_datapath_sva sva_i (
    .clk(clk), .i_rst_n(i_rst_n), .o_busy(o_busy), .o_done(o_done),
    .o_mem_rd(o_mem_rd), .o_mem_wr(o_mem_wr), .o_stream_valid(o_stream_valid),
    .i_stream_ready(i_stream_ready), .o_stream_data(o_stream_data)
);

// File: src/vec_datapath.sv
`timescale 1ns/1ns

module vec_datapath #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic            clk,
    input  logic            i_rst_n,
    // instruction issue
    input  logic            i_instr_valid,
    input  vec_pkg::instr_t i_instr,
    output logic            o_busy,
    output logic            o_done,
    // memory port
    output logic            o_mem_rd,
    output logic            o_mem_wr,
    output vec_pkg::maddr_t o_mem_addr,
    output vec_pkg::vword_t o_mem_wdata,
    input  logic            i_mem_rvalid,
    input  vec_pkg::vword_t i_mem_rdata,
    // streams
    input  logic            i_stream_valid,
    input  vec_pkg::vword_t i_stream_data,
    output logic            o_stream_ready,
    output logic            o_stream_valid,
    output vec_pkg::vword_t o_stream_data,
    input  logic            i_stream_ready
);
    logic            start;
    vec_pkg::vop_e   op;
    vec_pkg::vaddr_t vd, vs, len_m1;
    vec_pkg::maddr_t base;
    vec_pkg::vaddr_t rd_addr_a, rd_addr_b, load_waddr;
    vec_pkg::vword_t rdata_a, rdata_b;
    logic            seq_rd, seq_wr;
    vec_pkg::maddr_t seq_addr;
    logic            load_valid;
    vec_pkg::vword_t load_data;
    logic            in_pop, in_empty, in_full;
    logic            out_push, out_empty, out_full;
    vec_pkg::vword_t in_head;
    logic            pe_issue, pe_valid;
    vec_pkg::vaddr_t pe_waddr;
    vec_pkg::vword_t pe_result;
    logic            rf_we;
    vec_pkg::vaddr_t rf_waddr;
    vec_pkg::vword_t rf_wdata;

    assign o_stream_ready = !in_full;
    assign o_stream_valid = !out_empty;

    // write source picked by the running op
    assign rf_we    = (op == vec_pkg::VMACC) ? pe_valid : ((op == vec_pkg::VLOAD) && load_valid);
    assign rf_waddr = (op == vec_pkg::VMACC) ? pe_waddr  : load_waddr;
    assign rf_wdata = (op == vec_pkg::VMACC) ? pe_result : load_data;

    vec_decoder dec_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_start(start), .o_op(op), .o_vd(vd), .o_vs(vs), .o_len_m1(len_m1), .o_base(base)
    );

    vec_sequencer seq_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_op(op), .i_vd(vd), .i_vs(vs),
        .i_len_m1(len_m1), .i_base(base), .i_rvalid(load_valid), .i_in_empty(in_empty),
        .i_out_full(out_full), .i_pe_valid(pe_valid), .o_rd_addr_a(rd_addr_a),
        .o_rd_addr_b(rd_addr_b), .o_mem_rd(seq_rd), .o_mem_wr(seq_wr), .o_mem_addr(seq_addr),
        .o_load_waddr(load_waddr), .o_in_pop(in_pop), .o_out_push(out_push),
        .o_pe_issue(pe_issue), .o_busy(o_busy), .o_done(o_done)
    );

    vec_regfile rf_i (
        .clk(clk), .i_we(rf_we), .i_waddr(rf_waddr), .i_wdata(rf_wdata),
        .i_raddr_a(rd_addr_a), .i_raddr_b(rd_addr_b), .o_rdata_a(rdata_a), .o_rdata_b(rdata_b)
    );

    // stream word times vs entry plus vd entry
    vec_mac_pe pe_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_issue(pe_issue), .i_waddr(rd_addr_b),
        .i_a(in_head), .i_b(rdata_a), .i_acc(rdata_b),
        .o_valid(pe_valid), .o_waddr(pe_waddr), .o_result(pe_result)
    );

    mem_port mem_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_rd(seq_rd), .i_wr(seq_wr), .i_addr(seq_addr),
        .i_wdata(rdata_a), .i_mem_rvalid(i_mem_rvalid), .i_mem_rdata(i_mem_rdata),
        .o_mem_rd(o_mem_rd), .o_mem_wr(o_mem_wr), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .o_rvalid(load_valid), .o_rdata(load_data)
    );

    stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) in_fifo_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_push(i_stream_valid && !in_full), .i_pop(in_pop),
        .i_din(i_stream_data), .o_dout(in_head), .o_empty(in_empty), .o_full(in_full)
    );

    stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) out_fifo_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_push(out_push), .i_pop(i_stream_ready && !out_empty),
        .i_din(rdata_a), .o_dout(o_stream_data), .o_empty(out_empty), .o_full(out_full)
    );

endmodule

// File: src/mem_port.sv
`timescale 1ns/1ns

module mem_port (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_rd,
    input  logic            i_wr,
    input  vec_pkg::maddr_t i_addr,
    input  vec_pkg::vword_t i_wdata,
    input  logic            i_mem_rvalid,
    input  vec_pkg::vword_t i_mem_rdata,
    output logic            o_mem_rd,
    output logic            o_mem_wr,
    output vec_pkg::maddr_t o_mem_addr,
    output vec_pkg::vword_t o_mem_wdata,
    output logic            o_rvalid,
    output vec_pkg::vword_t o_rdata
);

    // strobes and load valid
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mem_rd <= 1'b0;
            o_mem_wr <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            o_mem_rd <= i_rd;
            o_mem_wr <= i_wr;
            o_rvalid <= i_mem_rvalid;   // one-cycle pulse into the RF write port
        end
    end

    // address and write data held between requests
    always_ff @(posedge clk) begin
        if (i_rd || i_wr) begin
            o_mem_addr <= i_addr;
        end
        if (i_wr) begin
            o_mem_wdata <= i_wdata;
        end
    end

    // returned read data
    always_ff @(posedge clk) begin
        if (i_mem_rvalid) o_rdata <= i_mem_rdata;
    end

endmodule

// File: lane/vec_mac_pe.sv
`timescale 1ns/1ns

module vec_mac_pe (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_issue,
    input  vec_pkg::vaddr_t i_waddr,
    input  vec_pkg::vword_t i_a,
    input  vec_pkg::vword_t i_b,
    input  vec_pkg::vword_t i_acc,
    output logic            o_valid,
    output vec_pkg::vaddr_t o_waddr,
    output vec_pkg::vword_t o_result
);
    localparam int W = vec_pkg::LANE_W;

    vec_pkg::lane_t  prod_q [vec_pkg::LANES];
    vec_pkg::vword_t acc_q;
    vec_pkg::vaddr_t waddr_q;
    logic            valid_q;

    // valid travels with the data
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_issue;
            o_valid <= valid_q;
        end
    end

    // stage 1, lane products
    always_ff @(posedge clk) begin
        for (int l = 0; l < vec_pkg::LANES; l++) begin
            prod_q[l] <= vec_pkg::lane_t'(i_a[l*W +: W] * i_b[l*W +: W]);
        end
        acc_q   <= i_acc;
        waddr_q <= i_waddr;
    end

    // stage 2, accumulate, wraps mod 2^16
    always_ff @(posedge clk) begin
        for (int l = 0; l < vec_pkg::LANES; l++) begin
            o_result[l*W +: W] <= prod_q[l] + acc_q[l*W +: W];
        end
        o_waddr <= waddr_q;
    end

endmodule

// File: lane/vec_regfile.sv
`timescale 1ns/1ns

module vec_regfile (
    input  logic            clk,
    input  logic            i_we,
    input  vec_pkg::vaddr_t i_waddr,
    input  vec_pkg::vword_t i_wdata,
    input  vec_pkg::vaddr_t i_raddr_a,
    input  vec_pkg::vaddr_t i_raddr_b,
    output vec_pkg::vword_t o_rdata_a,
    output vec_pkg::vword_t o_rdata_b
);
    vec_pkg::vword_t rf [vec_pkg::VRF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) rf[i_waddr] <= i_wdata;
    end

    // A feeds store, stream out and MAC multiplicand
    assign o_rdata_a = rf[i_raddr_a];
    assign o_rdata_b = rf[i_raddr_b];   // accumulator read

endmodule

// File: control/vec_sequencer.sv
`timescale 1ns/1ns

module vec_sequencer (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_start,
    input  vec_pkg::vop_e   i_op,
    input  vec_pkg::vaddr_t i_vd,
    input  vec_pkg::vaddr_t i_vs,
    input  vec_pkg::vaddr_t i_len_m1,
    input  vec_pkg::maddr_t i_base,
    input  logic            i_rvalid,
    input  logic            i_in_empty,
    input  logic            i_out_full,
    input  logic            i_pe_valid,
    output vec_pkg::vaddr_t o_rd_addr_a,
    output vec_pkg::vaddr_t o_rd_addr_b,
    output logic            o_mem_rd,
    output logic            o_mem_wr,
    output vec_pkg::maddr_t o_mem_addr,
    output vec_pkg::vaddr_t o_load_waddr,
    output logic            o_in_pop,
    output logic            o_out_push,
    output logic            o_pe_issue,
    output logic            o_busy,
    output logic            o_done
);
    typedef enum logic [2:0] {IDLE, LOAD_REQ, LOAD_WAIT, RUN, DRAIN} state_e;

    state_e          state;
    state_e          state_nxt;
    vec_pkg::vaddr_t elem;          // element index k
    logic [1:0]      in_flight;     // MACs still in the PE
    logic            wr_q;          // store still in mem_port
    logic            last;
    logic            step;

    assign last = (elem == i_len_m1);

    // addresses wrap at 16 in the register file
    assign o_rd_addr_a  = i_vs + elem;
    assign o_rd_addr_b  = i_vd + elem;
    assign o_load_waddr = i_vd + elem;
    assign o_mem_addr   = i_base + vec_pkg::maddr_t'(elem);

    assign o_busy = (state != IDLE) || i_start;

    always_comb begin
        state_nxt  = state;
        step       = 1'b0;
        o_mem_rd   = 1'b0;
        o_mem_wr   = 1'b0;
        o_in_pop   = 1'b0;
        o_out_push = 1'b0;
        o_pe_issue = 1'b0;
        o_done     = 1'b0;
        case (state)
            IDLE: begin
                if (i_start) state_nxt = (i_op == vec_pkg::VLOAD) ? LOAD_REQ : RUN;
            end
            LOAD_REQ: begin
                o_mem_rd  = 1'b1;
                state_nxt = LOAD_WAIT;
            end
            LOAD_WAIT: begin
                if (i_rvalid) begin     // stalled until the response lands
                    step = 1'b1;
                    if (last) begin
                        o_done    = 1'b1;
                        state_nxt = IDLE;
                    end else begin
                        state_nxt = LOAD_REQ;
                    end
                end
            end
            RUN: begin
                case (i_op)
                    vec_pkg::VSTORE: begin
                        o_mem_wr = 1'b1;
                        step     = 1'b1;
                    end
                    vec_pkg::VMACC: begin
                        if (!i_in_empty) begin
                            o_in_pop   = 1'b1;
                            o_pe_issue = 1'b1;
                            step       = 1'b1;
                        end
                    end
                    vec_pkg::VSTREAMOUT: begin
                        if (!i_out_full) begin
                            o_out_push = 1'b1;
                            step       = 1'b1;
                        end
                    end
                    default: ;
                endcase
                if (step && last) begin
                    // stream out has nothing left behind it
                    if (i_op == vec_pkg::VSTREAMOUT) begin
                        o_done    = 1'b1;
                        state_nxt = IDLE;
                    end else begin
                        state_nxt = DRAIN;
                    end
                end
            end
            DRAIN: begin
                if (in_flight == 2'd0 && !wr_q) begin
                    o_done    = 1'b1;
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            elem      <= '0;
            in_flight <= 2'd0;
            wr_q      <= 1'b0;
        end else begin
            state     <= state_nxt;
            wr_q      <= o_mem_wr;
            in_flight <= in_flight + {1'b0, o_pe_issue} - {1'b0, i_pe_valid};
            if (i_start) begin
                elem <= '0;
            end else if (step && !last) begin
                elem <= elem + vec_pkg::vaddr_t'(1);
            end
        end
    end

endmodule

// File: control/vec_decoder.sv
`timescale 1ns/1ns

module vec_decoder (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_instr_valid,
    input  vec_pkg::instr_t i_instr,
    output logic            o_start,
    output vec_pkg::vop_e   o_op,
    output vec_pkg::vaddr_t o_vd,
    output vec_pkg::vaddr_t o_vs,
    output vec_pkg::vaddr_t o_len_m1,
    output vec_pkg::maddr_t o_base
);

    // start strobe and opcode
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_start <= 1'b0;
            o_op    <= vec_pkg::VLOAD;
        end else begin
            o_start <= i_instr_valid;   // one cycle behind issue
            if (i_instr_valid) begin
                o_op <= vec_pkg::vop_e'(i_instr[vec_pkg::OP_HI:vec_pkg::OP_LO]);
            end
        end
    end

    // operand fields, held until the next issue
    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            o_vd     <= i_instr[vec_pkg::VD_HI:vec_pkg::VD_LO];
            o_vs     <= i_instr[vec_pkg::VS_HI:vec_pkg::VS_LO];
            o_len_m1 <= i_instr[vec_pkg::LEN_HI:vec_pkg::LEN_LO];
            o_base   <= i_instr[vec_pkg::BASE_HI:vec_pkg::BASE_LO];
        end
    end

endmodule

// File: src/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_push,
    input  logic            i_pop,
    input  vec_pkg::vword_t i_din,
    output vec_pkg::vword_t o_dout,
    output logic            o_empty,
    output logic            o_full
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    vec_pkg::vword_t  mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(FIFO_DEPTH));
    assign do_push = i_push && !o_full;     // push on full dropped
    assign do_pop  = i_pop && !o_empty;
    assign o_dout  = mem[rd_ptr];           // head visible without a pop

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= i_din;
    end

endmodule

// File: common/vec_pkg.sv
package vec_pkg;

    // SIMD geometry
    localparam int LANES   = 4;
    localparam int LANE_W  = 16;
    localparam int WORD_W  = LANES * LANE_W;    // one vector word, 64 bits

    // register file and memory
    localparam int VRF_DEPTH = 16;
    localparam int VRF_AW    = 4;
    localparam int MEM_AW    = 16;              // word address, not byte
    localparam int INSTR_W   = 32;

    typedef logic [WORD_W-1:0]  vword_t;
    typedef logic [LANE_W-1:0]  lane_t;
    typedef logic [VRF_AW-1:0]  vaddr_t;
    typedef logic [MEM_AW-1:0]  maddr_t;
    typedef logic [INSTR_W-1:0] instr_t;

    typedef enum logic [1:0] {
        VLOAD      = 2'd0,
        VSTORE     = 2'd1,
        VMACC      = 2'd2,
        VSTREAMOUT = 2'd3
    } vop_e;

    // instruction fields
    localparam int OP_HI   = 31;
    localparam int OP_LO   = 30;
    localparam int VD_HI   = 29;
    localparam int VD_LO   = 26;
    localparam int VS_HI   = 25;
    localparam int VS_LO   = 22;
    localparam int LEN_HI  = 21;                // run length minus one
    localparam int LEN_LO  = 18;
    localparam int BASE_HI = 15;                // bits 17:16 unused
    localparam int BASE_LO = 0;

endpackage
